// ==== hw/rv_pkg.sv ====
package rv_pkg;

    // data and index widths.
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;

    typedef enum logic [3:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic [1:0]
    {
        OP2_REG,
        OP2_IMM_I,
        OP2_IMM_J
    } op2_src_e;

    typedef enum logic
    {
        FWD_REGFILE,
        FWD_WB
    } fwd_sel_e;

    // branch conditions, rv32i encoding.
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // subtract and compares run as op1 + ~op2 + 1.
    function automatic logic op2_inverse_f(input alu_op_e op);
        logic inv;
        case (op)
            ALU_SUB, ALU_SLT, ALU_SLTU:
                inv = 1'b1;
            default:
                inv = 1'b0;
        endcase
        return inv;
    endfunction

endpackage

// ==== hw/rv_ex_if.sv ====
`timescale 1ns/10ps

interface ex_stage_if import rv_pkg::*;
#(
    parameter int IADDR_BITS = 32
);

    logic                  valid;
    reg_idx_t              rd;
    logic                  reg_write;
    word_t                 op1;
    word_t                 op2;
    alu_op_e               alu_op;
    funct3_t               funct3;
    logic                  jal_jalr;
    logic                  branch;
    logic [IADDR_BITS-1:0] pc;
    logic [IADDR_BITS-1:0] pc_next;
    logic [IADDR_BITS-1:0] pc_target;
    logic                  branch_pred;
    reg_idx_t              rs1;
    reg_idx_t              rs2;
    word_t                 reg1_data;
    word_t                 reg2_data;

    modport producer
    (
        output valid, rd, reg_write, op1, op2, alu_op, funct3, jal_jalr, branch,
               pc, pc_next, pc_target, branch_pred, rs1, rs2, reg1_data, reg2_data
    );

    modport consumer
    (
        input valid, rd, reg_write, op1, op2, alu_op, funct3, jal_jalr, branch,
              pc, pc_next, pc_target, branch_pred, rs1, rs2, reg1_data, reg2_data
    );

endinterface

// ==== hw/rv_regfile.sv ====
`timescale 1ns/10ps

module rv_regfile import rv_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst,
    input  reg_idx_t i_rd_addr1,
    input  reg_idx_t i_rd_addr2,
    output word_t    o_rd_data1,
    output word_t    o_rd_data2,
    input  logic     i_we,
    input  reg_idx_t i_wr_addr,
    input  word_t    i_wr_data
);

    // x0 has no storage.
    word_t regs [1:31];

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            for (int i = 1; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (i_we && (i_wr_addr != '0))
        begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    always_comb
    begin
        o_rd_data1 = '0;
        o_rd_data2 = '0;
        if (i_rd_addr1 != '0)
        begin
            o_rd_data1 = regs[i_rd_addr1];
        end
        if (i_rd_addr2 != '0)
        begin
            o_rd_data2 = regs[i_rd_addr2];
        end
    end

endmodule

// ==== hw/rv_opsel.sv ====
`timescale 1ns/10ps

module rv_opsel import rv_pkg::*;
#(
    parameter int IADDR_BITS = 32
)
(
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_flush,
    input  logic                  i_valid,
    input  logic [IADDR_BITS-1:0] i_pc,
    input  logic [IADDR_BITS-1:0] i_pc_next,
    input  logic                  i_branch_pred,
    input  reg_idx_t              i_rs1,
    input  reg_idx_t              i_rs2,
    input  reg_idx_t              i_rd,
    input  word_t                 i_imm_i,
    input  word_t                 i_imm_j,
    input  alu_op_e               i_alu_op,
    input  logic                  i_op1_pc,
    input  op2_src_e              i_op2_src,
    input  funct3_t               i_funct3,
    input  logic                  i_reg_write,
    input  logic                  i_inst_jal,
    input  logic                  i_inst_jalr,
    input  logic                  i_inst_branch,
    input  word_t                 i_rf_data1,
    input  word_t                 i_rf_data2,
    input  word_t                 i_wb_data,
    input  fwd_sel_e              i_fwd1,
    input  fwd_sel_e              i_fwd2,
    output reg_idx_t              o_rs1,
    output reg_idx_t              o_rs2,
    ex_stage_if.producer          ex
);

    logic                  valid;
    logic [IADDR_BITS-1:0] pc;
    logic [IADDR_BITS-1:0] pc_next;
    logic                  branch_pred;
    reg_idx_t              rs1;
    reg_idx_t              rs2;
    reg_idx_t              rd;
    word_t                 imm_i;
    word_t                 imm_j;
    alu_op_e               alu_op;
    logic                  op1_pc;
    op2_src_e              op2_src;
    funct3_t               funct3;
    logic                  reg_write;
    logic                  inst_jal;
    logic                  inst_jalr;
    logic                  inst_branch;

    always_ff @(posedge i_clk)
    begin
        if (i_rst | i_flush)
        begin
            valid       <= 1'b0;
            rd          <= '0;
            reg_write   <= 1'b0;
            inst_jal    <= 1'b0;
            inst_jalr   <= 1'b0;
            inst_branch <= 1'b0;
            branch_pred <= 1'b0;
        end
        else
        begin
            valid       <= i_valid;
            pc          <= i_pc;
            pc_next     <= i_pc_next;
            branch_pred <= i_branch_pred;
            rs1         <= i_rs1;
            rs2         <= i_rs2;
            rd          <= i_rd;
            imm_i       <= i_imm_i;
            imm_j       <= i_imm_j;
            alu_op      <= i_alu_op;
            op1_pc      <= i_op1_pc;
            op2_src     <= i_op2_src;
            funct3      <= i_funct3;
            reg_write   <= i_reg_write;
            inst_jal    <= i_inst_jal;
            inst_jalr   <= i_inst_jalr;
            inst_branch <= i_inst_branch;
        end
    end

    word_t                 reg1;
    word_t                 reg2;
    word_t                 op2_pre;
    logic [IADDR_BITS-1:0] target_base;
    logic [IADDR_BITS-1:0] target_offset;
    logic [IADDR_BITS-1:0] target_sum;

    // bypass the result still sitting in writeback.
    assign reg1 = (i_fwd1 == FWD_WB) ? i_wb_data : i_rf_data1;
    assign reg2 = (i_fwd2 == FWD_WB) ? i_wb_data : i_rf_data2;

    always_comb
    begin
        case (op2_src)
            OP2_IMM_I: op2_pre = imm_i;
            OP2_IMM_J: op2_pre = imm_j;
            default:   op2_pre = reg2;
        endcase
    end

    assign target_base   = inst_jalr ? reg1[IADDR_BITS-1:0] : pc;
    assign target_offset = inst_jalr ? imm_i[IADDR_BITS-1:0] : imm_j[IADDR_BITS-1:0];
    assign target_sum    = target_base + target_offset;

    assign ex.valid       = valid;
    assign ex.rd          = rd;
    assign ex.reg_write   = reg_write;
    assign ex.op1         = op1_pc ? word_t'(pc) : reg1;
    assign ex.op2         = op2_inverse_f(alu_op) ? ~op2_pre : op2_pre;
    assign ex.alu_op      = alu_op;
    assign ex.funct3      = funct3;
    assign ex.jal_jalr    = inst_jal | inst_jalr;
    assign ex.branch      = inst_branch;
    assign ex.pc          = pc;
    assign ex.pc_next     = pc_next;
    // jalr needs bit 0 dropped.
    assign ex.pc_target   = {target_sum[IADDR_BITS-1:1], 1'b0};
    assign ex.branch_pred = branch_pred;
    assign ex.rs1         = rs1;
    assign ex.rs2         = rs2;
    assign ex.reg1_data   = reg1;
    assign ex.reg2_data   = reg2;

    assign o_rs1 = rs1;
    assign o_rs2 = rs2;

endmodule

// ==== hw/rv_alu.sv ====
`timescale 1ns/10ps

module rv_alu import rv_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst,
    ex_stage_if.consumer ex,
    output logic         o_wb_valid,
    output reg_idx_t     o_wb_rd,
    output word_t        o_wb_data,
    output logic         o_wb_we
);

    logic       carry;
    word_t      sum;
    logic       lt_s;
    logic       lt_u;
    logic [4:0] shamt;
    word_t      alu_res;
    word_t      result;

    // op2 arrives inverted for sub and compares.
    assign {carry, sum} = {1'b0, ex.op1} + {1'b0, ex.op2} + 33'(op2_inverse_f(ex.alu_op));

    // equal signs of op1 and ~b mean the true operands differ in sign.
    assign lt_s  = (ex.op1[31] == ex.op2[31]) ? ex.op1[31] : sum[31];
    assign lt_u  = ~carry;
    assign shamt = ex.op2[4:0];

    always_comb
    begin
        case (ex.alu_op)
            ALU_SLL:  alu_res = ex.op1 << shamt;
            ALU_SLT:  alu_res = word_t'(lt_s);
            ALU_SLTU: alu_res = word_t'(lt_u);
            ALU_XOR:  alu_res = ex.op1 ^ ex.op2;
            ALU_SRL:  alu_res = ex.op1 >> shamt;
            ALU_SRA:  alu_res = word_t'($signed(ex.op1) >>> shamt);
            ALU_OR:   alu_res = ex.op1 | ex.op2;
            ALU_AND:  alu_res = ex.op1 & ex.op2;
            default:  alu_res = sum;
        endcase
    end

    // link address for jumps.
    assign result = ex.jal_jalr ? word_t'(ex.pc_next) : alu_res;

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            o_wb_valid <= 1'b0;
            o_wb_we    <= 1'b0;
            o_wb_rd    <= '0;
            o_wb_data  <= '0;
        end
        else
        begin
            o_wb_valid <= ex.valid;
            o_wb_we    <= ex.valid & ex.reg_write;
            if (ex.valid)
            begin
                o_wb_rd   <= ex.rd;
                o_wb_data <= result;
            end
        end
    end

endmodule

// ==== hw/rv_branch_unit.sv ====
`timescale 1ns/10ps

module rv_branch_unit import rv_pkg::*;
#(
    parameter int IADDR_BITS = 32
)
(
    input  logic                  i_clk,
    input  logic                  i_rst,
    ex_stage_if.consumer          ex,
    output logic                  o_mispredict,
    output logic                  o_redirect,
    output logic [IADDR_BITS-1:0] o_redirect_pc
);

    logic                  cond;
    logic                  taken;
    logic [IADDR_BITS-1:0] next_pc;

    always_comb
    begin
        case (ex.funct3)
            F3_BEQ:  cond = (ex.reg1_data == ex.reg2_data);
            F3_BNE:  cond = (ex.reg1_data != ex.reg2_data);
            F3_BLT:  cond = ($signed(ex.reg1_data) < $signed(ex.reg2_data));
            F3_BGE:  cond = ($signed(ex.reg1_data) >= $signed(ex.reg2_data));
            F3_BLTU: cond = (ex.reg1_data < ex.reg2_data);
            F3_BGEU: cond = (ex.reg1_data >= ex.reg2_data);
            default: cond = 1'b0;
        endcase
    end

    assign taken   = ex.jal_jalr | (ex.branch & cond);
    assign next_pc = taken ? ex.pc_target : ex.pc_next;

    // jumps count as predicted only when flagged taken.
    assign o_mispredict = ex.valid &
                          ((ex.branch & (cond != ex.branch_pred)) |
                           (ex.jal_jalr & ~ex.branch_pred));

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            o_redirect    <= 1'b0;
            o_redirect_pc <= '0;
        end
        else
        begin
            o_redirect <= o_mispredict;
            if (o_mispredict)
            begin
                o_redirect_pc <= next_pc;
            end
        end
    end

endmodule

// ==== hw/rv_ex_ctrl.sv ====
`timescale 1ns/10ps

module rv_ex_ctrl import rv_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst,
    ex_stage_if.consumer ex,
    input  logic         i_mispredict,
    input  logic         i_wb_valid,
    input  logic         i_wb_we,
    input  reg_idx_t     i_wb_rd,
    output fwd_sel_e     o_fwd1,
    output fwd_sel_e     o_fwd2,
    output logic         o_flush
);

    logic wb_live;
    logic flush_q;

    // result not yet in the register file.
    assign wb_live = i_wb_valid & i_wb_we & (i_wb_rd != '0);

    always_comb
    begin
        o_fwd1 = FWD_REGFILE;
        o_fwd2 = FWD_REGFILE;
        if (wb_live && (i_wb_rd == ex.rs1))
        begin
            o_fwd1 = FWD_WB;
        end
        if (wb_live && (i_wb_rd == ex.rs2))
        begin
            o_fwd2 = FWD_WB;
        end
    end

    // one flush per redirect, only the next slot is dropped.
    assign o_flush = i_mispredict & ~flush_q;

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            flush_q <= 1'b0;
        end
        else
        begin
            flush_q <= o_flush;
        end
    end

endmodule

// ==== hw/rv_ex_top.sv ====
`timescale 1ns/10ps

module rv_ex_top import rv_pkg::*;
#(
    parameter int IADDR_BITS = 32
)
(
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_valid,
    input  logic [IADDR_BITS-1:0] i_pc,
    input  logic [IADDR_BITS-1:0] i_pc_next,
    input  logic                  i_branch_pred,
    input  reg_idx_t              i_rs1,
    input  reg_idx_t              i_rs2,
    input  reg_idx_t              i_rd,
    input  word_t                 i_imm_i,
    input  word_t                 i_imm_j,
    input  alu_op_e               i_alu_op,
    input  logic                  i_op1_pc,
    input  op2_src_e              i_op2_src,
    input  funct3_t               i_funct3,
    input  logic                  i_reg_write,
    input  logic                  i_inst_jal,
    input  logic                  i_inst_jalr,
    input  logic                  i_inst_branch,
    output logic                  o_wb_valid,
    output reg_idx_t              o_wb_rd,
    output word_t                 o_wb_data,
    output logic                  o_redirect,
    output logic [IADDR_BITS-1:0] o_redirect_pc
);

    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rf_data1;
    word_t    rf_data2;
    logic     wb_we;
    fwd_sel_e fwd1;
    fwd_sel_e fwd2;
    logic     flush;
    logic     mispredict;

    ex_stage_if #(.IADDR_BITS(IADDR_BITS)) ex_if ();

    rv_regfile i_rv_regfile
    (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_rd_addr1 (rs1),
        .i_rd_addr2 (rs2),
        .o_rd_data1 (rf_data1),
        .o_rd_data2 (rf_data2),
        .i_we       (wb_we),
        .i_wr_addr  (o_wb_rd),
        .i_wr_data  (o_wb_data)
    );

    rv_opsel #(.IADDR_BITS(IADDR_BITS)) i_rv_opsel
    (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_flush       (flush),
        .i_valid       (i_valid),
        .i_pc          (i_pc),
        .i_pc_next     (i_pc_next),
        .i_branch_pred (i_branch_pred),
        .i_rs1         (i_rs1),
        .i_rs2         (i_rs2),
        .i_rd          (i_rd),
        .i_imm_i       (i_imm_i),
        .i_imm_j       (i_imm_j),
        .i_alu_op      (i_alu_op),
        .i_op1_pc      (i_op1_pc),
        .i_op2_src     (i_op2_src),
        .i_funct3      (i_funct3),
        .i_reg_write   (i_reg_write),
        .i_inst_jal    (i_inst_jal),
        .i_inst_jalr   (i_inst_jalr),
        .i_inst_branch (i_inst_branch),
        .i_rf_data1    (rf_data1),
        .i_rf_data2    (rf_data2),
        .i_wb_data     (o_wb_data),
        .i_fwd1        (fwd1),
        .i_fwd2        (fwd2),
        .o_rs1         (rs1),
        .o_rs2         (rs2),
        .ex            (ex_if.producer)
    );

    rv_alu i_rv_alu
    (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .ex         (ex_if.consumer),
        .o_wb_valid (o_wb_valid),
        .o_wb_rd    (o_wb_rd),
        .o_wb_data  (o_wb_data),
        .o_wb_we    (wb_we)
    );

    rv_branch_unit #(.IADDR_BITS(IADDR_BITS)) i_rv_branch_unit
    (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .ex            (ex_if.consumer),
        .o_mispredict  (mispredict),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc)
    );

    rv_ex_ctrl i_rv_ex_ctrl
    (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .ex           (ex_if.consumer),
        .i_mispredict (mispredict),
        .i_wb_valid   (o_wb_valid),
        .i_wb_we      (wb_we),
        .i_wb_rd      (o_wb_rd),
        .o_fwd1       (fwd1),
        .o_fwd2       (fwd2),
        .o_flush      (flush)
    );

endmodule

// ==== tests/tb_rv_ex.sv ====
`timescale 1ns/10ps

module tb_rv_ex import rv_pkg::*;
();

    localparam int NUM_VEC    = 44;
    localparam int NUM_FIELD  = 23;
    localparam int IDLE_LIMIT = 20;

    logic        i_clk;
    logic        i_rst;
    logic        i_valid;
    logic [31:0] i_pc;
    logic [31:0] i_pc_next;
    logic        i_branch_pred;
    reg_idx_t    i_rs1;
    reg_idx_t    i_rs2;
    reg_idx_t    i_rd;
    word_t       i_imm_i;
    word_t       i_imm_j;
    alu_op_e     i_alu_op;
    logic        i_op1_pc;
    op2_src_e    i_op2_src;
    funct3_t     i_funct3;
    logic        i_reg_write;
    logic        i_inst_jal;
    logic        i_inst_jalr;
    logic        i_inst_branch;
    logic        o_wb_valid;
    reg_idx_t    o_wb_rd;
    word_t       o_wb_data;
    logic        o_redirect;
    logic [31:0] o_redirect_pc;

    // one row of NUM_FIELD words per vector.
    logic [31:0] vec_mem [0:NUM_VEC*NUM_FIELD-1];

    int vec_errors;
    int tests_passed;
    int tests_failed;
    int cyc;
    bit timed_out;
    bit load_error;

    rv_ex_top i_rv_ex_top
    (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_valid       (i_valid),
        .i_pc          (i_pc),
        .i_pc_next     (i_pc_next),
        .i_branch_pred (i_branch_pred),
        .i_rs1         (i_rs1),
        .i_rs2         (i_rs2),
        .i_rd          (i_rd),
        .i_imm_i       (i_imm_i),
        .i_imm_j       (i_imm_j),
        .i_alu_op      (i_alu_op),
        .i_op1_pc      (i_op1_pc),
        .i_op2_src     (i_op2_src),
        .i_funct3      (i_funct3),
        .i_reg_write   (i_reg_write),
        .i_inst_jal    (i_inst_jal),
        .i_inst_jalr   (i_inst_jalr),
        .i_inst_branch (i_inst_branch),
        .o_wb_valid    (o_wb_valid),
        .o_wb_rd       (o_wb_rd),
        .o_wb_data     (o_wb_data),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc)
    );

    initial
    begin
        i_clk = 1'b0;
        forever
        begin
            #20 i_clk = ~i_clk;
        end
    end

    task automatic drive_idle();
        i_valid       = 1'b0;
        i_pc          = '0;
        i_pc_next     = '0;
        i_branch_pred = 1'b0;
        i_rs1         = '0;
        i_rs2         = '0;
        i_rd          = '0;
        i_imm_i       = '0;
        i_imm_j       = '0;
        i_alu_op      = ALU_ADD;
        i_op1_pc      = 1'b0;
        i_op2_src     = OP2_REG;
        i_funct3      = '0;
        i_reg_write   = 1'b0;
        i_inst_jal    = 1'b0;
        i_inst_jalr   = 1'b0;
        i_inst_branch = 1'b0;
    endtask

    task automatic drive_vector(input int vec);
        int base;
        base          = vec * NUM_FIELD;
        i_valid       = vec_mem[base+1][0];
        i_pc          = vec_mem[base+2];
        i_pc_next     = vec_mem[base+3];
        i_branch_pred = vec_mem[base+4][0];
        i_rs1         = vec_mem[base+5][4:0];
        i_rs2         = vec_mem[base+6][4:0];
        i_rd          = vec_mem[base+7][4:0];
        i_imm_i       = vec_mem[base+8];
        i_imm_j       = vec_mem[base+9];
        i_alu_op      = alu_op_e'(vec_mem[base+10][3:0]);
        i_op1_pc      = vec_mem[base+11][0];
        i_op2_src     = op2_src_e'(vec_mem[base+12][1:0]);
        i_funct3      = vec_mem[base+13][2:0];
        i_reg_write   = vec_mem[base+14][0];
        i_inst_jal    = vec_mem[base+15][0];
        i_inst_jalr   = vec_mem[base+16][0];
        i_inst_branch = vec_mem[base+17][0];
    endtask

    task automatic check_value(input int test_no, input string name,
                               input logic [31:0] got, input logic [31:0] expected);
        assert (got === expected)
        else
        begin
            $display("CHECK FAILED at time %0t: test %0d %s is %h, expected %h",
                     $time, test_no, name, got, expected);
            vec_errors++;
        end
    endtask

    task automatic check_vector(input int vec);
        int base;
        int test_no;
        base       = vec * NUM_FIELD;
        test_no    = vec_mem[base];
        vec_errors = 0;
        check_value(test_no, "wb_valid", 32'(o_wb_valid), vec_mem[base+18]);
        // rd and data hold their old value when nothing retires.
        if (vec_mem[base+18][0])
        begin
            check_value(test_no, "wb_rd", 32'(o_wb_rd), vec_mem[base+19]);
            check_value(test_no, "wb_data", o_wb_data, vec_mem[base+20]);
        end
        check_value(test_no, "redirect", 32'(o_redirect), vec_mem[base+21]);
        if (vec_mem[base+21][0])
        begin
            check_value(test_no, "redirect_pc", o_redirect_pc, vec_mem[base+22]);
        end
        if (vec_errors == 0)
        begin
            tests_passed++;
            $display("test %0d: passed", test_no);
        end
        else
        begin
            tests_failed++;
            $display("test %0d: failed with %0d mismatches", test_no, vec_errors);
        end
    endtask

    // no writeback and no redirect in flight.
    task automatic wait_idle(output bit expired);
        int cycles;
        cycles  = 0;
        expired = 1'b1;
        while (expired && (cycles < IDLE_LIMIT))
        begin
            @(posedge i_clk);
            #1;
            if (!o_wb_valid && !o_redirect)
            begin
                expired = 1'b0;
            end
            cycles++;
        end
    endtask

    initial
    begin
        tests_passed = 0;
        tests_failed = 0;
        vec_errors   = 0;
        timed_out    = 1'b0;
        drive_idle();
        i_rst = 1'b1;
        $readmemh("tests/ex_input.txt", vec_mem);
        load_error = $isunknown(vec_mem[NUM_VEC*NUM_FIELD-1]);
        repeat (4) @(posedge i_clk);
        #2;
        i_rst = 1'b0;
        if (!load_error)
        begin
            wait_idle(timed_out);
            if (!timed_out)
            begin
                // results of vector n show up two edges after it is driven.
                for (cyc = 0; cyc < NUM_VEC + 2; cyc++)
                begin
                    @(posedge i_clk);
                    #1;
                    if (cyc >= 2)
                    begin
                        check_vector(cyc - 2);
                    end
                    #1;
                    if (cyc < NUM_VEC)
                    begin
                        drive_vector(cyc);
                    end
                    else
                    begin
                        drive_idle();
                    end
                end
                wait_idle(timed_out);
            end
        end
        if (load_error)
        begin
            $display("could not read all vectors from tests/ex_input.txt");
        end
        if (timed_out)
        begin
            $display("outputs did not go idle within %0d cycles", IDLE_LIMIT);
        end
        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (load_error || timed_out || (tests_failed != 0))
        begin
            $display("Verification failed");
        end
        else
        begin
            $display("Verification passed");
        end
        $finish;
    end

endmodule

// ==== tests/ex_input.txt ====
// test valid pc pc_next pred rs1 rs2 rd imm_i imm_j alu op1_pc op2_src funct3 we jal jalr br
// then expected: wb_valid wb_rd wb_data redirect redirect_pc (all hex)
// alu ops, register and immediate operands
01 1 100 104 0 00 00 01 00000005 00000000 0 0 1 0 1 0 0 0   1 01 00000005 0 000
02 1 104 108 0 00 00 02 fffffffd 00000000 0 0 1 0 1 0 0 0   1 02 fffffffd 0 000
03 1 108 10c 0 01 02 03 00000000 00000000 0 0 0 0 1 0 0 0   1 03 00000002 0 000
04 1 10c 110 0 01 03 04 00000000 00000000 1 0 0 0 1 0 0 0   1 04 00000003 0 000
05 1 110 114 0 01 02 05 00000000 00000000 5 0 0 0 1 0 0 0   1 05 fffffff8 0 000
06 1 114 118 0 01 00 06 00000030 00000000 8 0 1 0 1 0 0 0   1 06 00000035 0 000
07 1 118 11c 0 02 00 07 000000ff 00000000 9 0 1 0 1 0 0 0   1 07 000000fd 0 000
08 1 11c 120 0 01 00 08 00000004 00000000 2 0 1 0 1 0 0 0   1 08 00000050 0 000
09 1 120 124 0 02 03 09 00000000 00000000 6 0 0 0 1 0 0 0   1 09 3fffffff 0 000
0a 1 124 128 0 02 00 0a 00000001 00000000 7 0 1 0 1 0 0 0   1 0a fffffffe 0 000
0b 1 128 12c 0 02 01 0b 00000000 00000000 3 0 0 0 1 0 0 0   1 0b 00000001 0 000
0c 1 12c 130 0 02 01 0c 00000000 00000000 4 0 0 0 1 0 0 0   1 0c 00000000 0 000
0d 1 130 134 0 01 02 0d 00000000 00000000 4 0 0 0 1 0 0 0   1 0d 00000001 0 000
0e 1 134 138 0 02 00 0e ffffffff 00000000 3 0 1 0 1 0 0 0   1 0e 00000001 0 000
// x0 write, register file readback, dependent chain
0f 1 138 13c 0 01 00 00 00000007 00000000 0 0 1 0 1 0 0 0   1 00 0000000c 0 000
10 1 13c 140 0 00 01 0f 00000000 00000000 0 0 0 0 1 0 0 0   1 0f 00000005 0 000
11 1 140 144 0 01 00 01 00000001 00000000 0 0 1 0 1 0 0 0   1 01 00000006 0 000
12 1 144 148 0 01 00 01 00000001 00000000 0 0 1 0 1 0 0 0   1 01 00000007 0 000
// jumps
13 1 200 204 0 00 00 10 00000000 00000040 0 1 2 0 1 1 0 0   1 10 00000204 1 240
14 1 204 208 0 00 00 11 00000063 00000000 0 0 1 0 1 0 0 0   0 00 00000000 0 000
15 1 240 244 0 01 00 12 00000100 00000000 0 0 1 0 1 0 1 0   1 12 00000244 1 106
16 1 244 248 0 00 00 13 00000001 00000000 0 0 1 0 1 0 0 0   0 00 00000000 0 000
17 1 300 304 1 00 00 14 00000000 00000100 0 1 2 0 1 1 0 0   1 14 00000304 0 000
18 1 400 404 0 12 14 15 00000000 00000000 0 0 0 0 1 0 0 0   1 15 00000548 0 000
// branches, every funct3, both outcomes and predictions
19 1 404 408 1 03 03 00 00000000 00000020 0 0 0 0 0 0 0 1   1 00 00000004 0 000
1a 1 424 428 1 01 03 00 00000000 00000020 0 0 0 0 0 0 0 1   1 00 00000009 1 428
1b 1 444 448 0 00 00 16 00000001 00000000 0 0 1 0 1 0 0 0   0 00 00000000 0 000
1c 1 428 42c 0 01 03 00 00000000 00000020 0 0 0 1 0 0 0 1   1 00 00000009 1 448
1d 0 000 000 0 00 00 00 00000000 00000000 0 0 0 0 0 0 0 0   0 00 00000000 0 000
1e 1 448 44c 0 03 03 00 00000000 00000020 0 0 0 1 0 0 0 1   1 00 00000004 0 000
1f 1 44c 450 1 02 01 00 00000000 00000020 0 0 0 4 0 0 0 1   1 00 00000004 0 000
20 1 46c 470 0 01 02 00 00000000 00000020 0 0 0 4 0 0 0 1   1 00 00000004 0 000
21 1 470 474 0 01 02 00 00000000 00000020 0 0 0 5 0 0 0 1   1 00 00000004 1 490
22 1 474 478 0 00 00 17 00000002 00000000 0 0 1 0 1 0 0 0   0 00 00000000 0 000
23 1 490 494 0 02 01 00 00000000 00000020 0 0 0 5 0 0 0 1   1 00 00000004 0 000
24 1 494 498 1 01 02 00 00000000 00000020 0 0 0 6 0 0 0 1   1 00 00000004 0 000
25 1 4b4 4b8 1 02 01 00 00000000 00000020 0 0 0 6 0 0 0 1   1 00 00000004 1 4b8
26 1 4d4 4d8 0 00 00 18 00000003 00000000 0 0 1 0 1 0 0 0   0 00 00000000 0 000
27 1 4b8 4bc 1 02 01 00 00000000 00000020 0 0 0 7 0 0 0 1   1 00 00000004 0 000
28 1 4d8 4dc 0 01 02 00 00000000 00000020 0 0 0 7 0 0 0 1   1 00 00000004 0 000
// flush drops one slot, the one after it retires
29 1 4dc 4e0 0 02 01 00 00000000 00000020 0 0 0 7 0 0 0 1   1 00 00000004 1 4fc
2a 1 4e0 4e4 0 00 00 19 00000011 00000000 0 0 1 0 1 0 0 0   0 00 00000000 0 000
2b 1 4fc 500 0 00 00 1a 00000022 00000000 0 0 1 0 1 0 0 0   1 1a 00000022 0 000
2c 1 500 504 0 19 1a 1b 00000000 00000000 0 0 0 0 1 0 0 0   1 1b 00000022 0 000

// ==== list.f ====
hw/rv_pkg.sv
hw/rv_ex_if.sv
hw/rv_regfile.sv
hw/rv_opsel.sv
hw/rv_alu.sv
hw/rv_branch_unit.sv
hw/rv_ex_ctrl.sv
hw/rv_ex_top.sv
tests/tb_rv_ex.sv

// ==== Bender.yml ====
package:
  name: rv_ex

sources:
  - hw/rv_pkg.sv
  - hw/rv_ex_if.sv
  - hw/rv_regfile.sv
  - hw/rv_opsel.sv
  - hw/rv_alu.sv
  - hw/rv_branch_unit.sv
  - hw/rv_ex_ctrl.sv
  - hw/rv_ex_top.sv
  - target: test
    files:
      - tests/tb_rv_ex.sv
